/* logic/video_out_pkg.sv */
// Shared video output definitions: pixel and analog structs, mode enums,
// OSD palette and RGB to YPbPr coefficients
package video_out_pkg;

    typedef logic [7:0] color_t;

    typedef struct packed {
        color_t r;
        color_t g;
        color_t b;
        logic   hsync;
        logic   vsync;
        logic   de;
    } video_pixel_t;

    typedef enum logic [1:0] {
        OSD_BLACK  = 2'd0,
        OSD_BLUE   = 2'd1,
        OSD_YELLOW = 2'd2,
        OSD_WHITE  = 2'd3
    } osd_color_t;

    // Indexed by osd_color_t, entry 0 is the rightmost
    localparam logic [3:0][23:0] OSD_PALETTE = {
        24'hffffff,
        24'hffff00,
        24'h0000ff,
        24'h000000
    };

    typedef enum logic [1:0] {
        EXP_SEL_OFF       = 2'd0,
        EXP_SEL_EXTRA_OUT = 2'd1,
        EXP_SEL_LEGACY_IN = 2'd2,
        EXP_SEL_UVC_BDG   = 2'd3
    } exp_sel_t;

    typedef enum logic [1:0] {
        EXTRA_OUT_RGBHV = 2'd0,
        EXTRA_OUT_RGBCS = 2'd1,
        EXTRA_OUT_RGSB  = 2'd2,
        EXTRA_OUT_YPBPR = 2'd3
    } extra_out_mode_t;

    typedef struct packed {
        color_t r;
        color_t g;
        color_t b;
        logic   hs;
        logic   vs;
        logic   blank_n;
        logic   sync_n;
    } analog_out_t;

    // BT.601 full range, 1/256 units
    localparam int CSC_Y_R  = 77;
    localparam int CSC_Y_G  = 150;
    localparam int CSC_Y_B  = 29;
    localparam int CSC_PB_R = -43;
    localparam int CSC_PB_G = -85;
    localparam int CSC_PB_B = 128;
    localparam int CSC_PR_R = 128;
    localparam int CSC_PR_G = -107;
    localparam int CSC_PR_B = -21;
    localparam int CSC_OFFSET = 128;

endpackage

/* logic/osd_mixer.sv */
// OSD colour substitution stage followed by the HDMI transmitter output register
`timescale 1ns/100ps

module osd_mixer #(
    parameter bit TX_LSB_ZERO = 1'b0
) (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  video_out_pkg::video_pixel_t pixel_i,
    input  logic                      osd_enable_i,
    input  video_out_pkg::osd_color_t osd_color_i,
    output video_out_pkg::video_pixel_t mixed_o,
    output video_out_pkg::video_pixel_t hdmi_pixel_o
);

    logic [23:0]                 osd_rgb;
    video_out_pkg::video_pixel_t mix_q;
    video_out_pkg::video_pixel_t tx_q;

    assign osd_rgb = video_out_pkg::OSD_PALETTE[osd_color_i];

    // Stage 1: palette colour replaces the picture, syncs and DE pass through
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mix_q <= '0;
        end else begin
            if (osd_enable_i) begin
                {mix_q.r, mix_q.g, mix_q.b} <= osd_rgb;
            end else begin
                mix_q.r <= pixel_i.r;
                mix_q.g <= pixel_i.g;
                mix_q.b <= pixel_i.b;
            end
            mix_q.hsync <= pixel_i.hsync;
            mix_q.vsync <= pixel_i.vsync;
            mix_q.de    <= pixel_i.de;
        end
    end

    // Stage 2: HDMI transmitter register
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            tx_q <= '0;
        end else begin
            tx_q      <= mix_q;
            // Red LSB line has crosstalk on some boards
            tx_q.r[0] <= TX_LSB_ZERO ? 1'b0 : mix_q.r[0];
        end
    end

    assign mixed_o      = mix_q;
    assign hdmi_pixel_o = tx_q;

    a_osd_palette: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        osd_enable_i |=> ({mixed_o.r, mixed_o.g, mixed_o.b} ==
                          video_out_pkg::OSD_PALETTE[$past(osd_color_i)])
    ) else $error("osd_mixer: OSD pixel differs from its palette entry");

endmodule

/* logic/ypbpr_csc.sv */
// RGB to YPbPr converter, two pipeline stages with matched sync delay
`timescale 1ns/100ps

module ypbpr_csc (
    input  logic                            clk_i,
    input  logic                            rst_n_i,
    input  video_out_pkg::video_pixel_t     pixel_i,
    input  video_out_pkg::exp_sel_t         exp_sel_i,
    input  video_out_pkg::extra_out_mode_t  extra_out_mode_i,
    output video_out_pkg::video_pixel_t     pixel_o
);

    typedef logic signed [17:0] product_t;
    typedef logic signed [19:0] acc_t;

    // Rows Y, Pb, Pr and columns R, G, B
    localparam int COEF [3][3] = '{
        '{video_out_pkg::CSC_Y_R,  video_out_pkg::CSC_Y_G,  video_out_pkg::CSC_Y_B},
        '{video_out_pkg::CSC_PB_R, video_out_pkg::CSC_PB_G, video_out_pkg::CSC_PB_B},
        '{video_out_pkg::CSC_PR_R, video_out_pkg::CSC_PR_G, video_out_pkg::CSC_PR_B}
    };

    logic                        csc_en;
    logic                        en_q;
    video_out_pkg::video_pixel_t pix_q;
    product_t                    prod_q [3][3];
    acc_t                        y_full;
    acc_t                        pb_full;
    acc_t                        pr_full;
    video_out_pkg::video_pixel_t out_q;

    function automatic product_t mult(input video_out_pkg::color_t c, input int coef);
        int p;
        p = int'(c) * coef;
        return product_t'(p);
    endfunction

    // Row sum scaled back by 256 with floor, then offset
    function automatic acc_t row_sum(input product_t p0, input product_t p1,
                                     input product_t p2, input int offset);
        acc_t sum;
        sum = acc_t'(p0) + acc_t'(p1) + acc_t'(p2);
        return (sum >>> 8) + acc_t'(offset);
    endfunction

    function automatic video_out_pkg::color_t clamp8(input acc_t val);
        video_out_pkg::color_t res;
        if (val < 0) begin
            res = 8'h00;
        end else if (val > 255) begin
            res = 8'hff;
        end else begin
            res = val[7:0];
        end
        return res;
    endfunction

    assign csc_en = (exp_sel_i == video_out_pkg::EXP_SEL_EXTRA_OUT) &&
                    (extra_out_mode_i == video_out_pkg::EXTRA_OUT_YPBPR);

    // Stage 1: products
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            en_q  <= 1'b0;
            pix_q <= '0;
            for (int row = 0; row < 3; row++) begin
                for (int col = 0; col < 3; col++) begin
                    prod_q[row][col] <= '0;
                end
            end
        end else begin
            en_q  <= csc_en;
            pix_q <= pixel_i;
            for (int row = 0; row < 3; row++) begin
                prod_q[row][0] <= mult(pixel_i.r, COEF[row][0]);
                prod_q[row][1] <= mult(pixel_i.g, COEF[row][1]);
                prod_q[row][2] <= mult(pixel_i.b, COEF[row][2]);
            end
        end
    end

    assign y_full  = row_sum(prod_q[0][0], prod_q[0][1], prod_q[0][2], 0);
    assign pb_full = row_sum(prod_q[1][0], prod_q[1][1], prod_q[1][2],
                             video_out_pkg::CSC_OFFSET);
    assign pr_full = row_sum(prod_q[2][0], prod_q[2][1], prod_q[2][2],
                             video_out_pkg::CSC_OFFSET);

    // Stage 2: sums and clamp, G carries Y
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            out_q <= '0;
        end else begin
            if (en_q) begin
                out_q.r <= clamp8(pr_full);
                out_q.g <= clamp8(y_full);
                out_q.b <= clamp8(pb_full);
            end else begin
                out_q.r <= pix_q.r;
                out_q.g <= pix_q.g;
                out_q.b <= pix_q.b;
            end
            out_q.hsync <= pix_q.hsync;
            out_q.vsync <= pix_q.vsync;
            out_q.de    <= pix_q.de;
        end
    end

    assign pixel_o = out_q;

    // Y coefficients sum to 256, so luma never needs clamping
    a_y_in_range: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        en_q |-> (y_full >= 0 && y_full <= 255)
    ) else $error("ypbpr_csc: Y out of range %0d", y_full);

endmodule

/* logic/analog_sync_encoder.sv */
// Sync format encoder and output enable for the expansion-port video DAC
`timescale 1ns/100ps

module analog_sync_encoder (
    input  logic                            clk_i,
    input  logic                            rst_n_i,
    input  video_out_pkg::video_pixel_t     pixel_i,
    input  video_out_pkg::exp_sel_t         exp_sel_i,
    input  video_out_pkg::extra_out_mode_t  extra_out_mode_i,
    output video_out_pkg::analog_out_t      analog_o,
    output logic                            vga_oe_o
);

    logic                       out_en;
    logic                       csync;
    video_out_pkg::analog_out_t enc;
    video_out_pkg::analog_out_t pre_q;
    video_out_pkg::analog_out_t analog_q;
    logic                       oe_q;

    assign out_en = (exp_sel_i == video_out_pkg::EXP_SEL_EXTRA_OUT);

    // Composite sync, active low
    assign csync = ~(pixel_i.hsync ^ pixel_i.vsync);

    always_comb begin
        enc.r = pixel_i.r;
        enc.g = pixel_i.g;
        enc.b = pixel_i.b;
        case (extra_out_mode_i)
            video_out_pkg::EXTRA_OUT_RGBHV: begin
                enc.hs      = pixel_i.hsync;
                enc.vs      = pixel_i.vsync;
                enc.blank_n = pixel_i.de;
                enc.sync_n  = 1'b0;
            end
            video_out_pkg::EXTRA_OUT_RGBCS: begin
                enc.hs      = csync;
                enc.vs      = 1'b1;
                enc.blank_n = pixel_i.de;
                enc.sync_n  = 1'b0;
            end
            video_out_pkg::EXTRA_OUT_RGSB: begin
                enc.hs      = csync;
                enc.vs      = 1'b1;
                enc.blank_n = pixel_i.de;
                enc.sync_n  = csync;
            end
            default: begin
                // YPbPr: sync on Y, DAC blanking not used
                enc.hs      = csync;
                enc.vs      = 1'b1;
                enc.blank_n = 1'b1;
                enc.sync_n  = csync;
            end
        endcase
    end

    // Both stages hold while the port is not an output
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pre_q    <= '0;
            analog_q <= '0;
        end else if (out_en) begin
            pre_q    <= enc;
            analog_q <= pre_q;
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            oe_q <= 1'b0;
        end else begin
            oe_q <= out_en;
        end
    end

    assign analog_o = analog_q;
    assign vga_oe_o = oe_q;

    a_hold_when_off: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        !$past(out_en) |-> $stable(analog_o)
    ) else $error("analog_sync_encoder: output moved while port disabled");

endmodule

/* logic/video_out_top.sv */
// Output pipeline top: OSD mixer, YPbPr converter and analog sync encoder
`timescale 1ns/100ps

module video_out_top #(
    parameter bit TX_LSB_ZERO = 1'b0
) (
    input  logic                            pclk_out,
    input  logic                            po_reset_n,
    input  video_out_pkg::video_pixel_t     pixel_i,
    input  logic                            osd_enable_i,
    input  video_out_pkg::osd_color_t       osd_color_i,
    input  video_out_pkg::exp_sel_t         exp_sel_i,
    input  video_out_pkg::extra_out_mode_t  extra_out_mode_i,
    output video_out_pkg::video_pixel_t     hdmi_pixel_o,
    output video_out_pkg::analog_out_t      analog_o,
    output logic                            vga_oe_o
);

    video_out_pkg::video_pixel_t mixed;
    video_out_pkg::video_pixel_t csc_pixel;

    osd_mixer #(
        .TX_LSB_ZERO (TX_LSB_ZERO)
    ) u_osd_mixer (
        .clk_i        (pclk_out),
        .rst_n_i      (po_reset_n),
        .pixel_i      (pixel_i),
        .osd_enable_i (osd_enable_i),
        .osd_color_i  (osd_color_i),
        .mixed_o      (mixed),
        .hdmi_pixel_o (hdmi_pixel_o)
    );

    // Analog branch taps the mixed stream before the HDMI register
    ypbpr_csc u_ypbpr_csc (
        .clk_i            (pclk_out),
        .rst_n_i          (po_reset_n),
        .pixel_i          (mixed),
        .exp_sel_i        (exp_sel_i),
        .extra_out_mode_i (extra_out_mode_i),
        .pixel_o          (csc_pixel)
    );

    analog_sync_encoder u_analog_sync_encoder (
        .clk_i            (pclk_out),
        .rst_n_i          (po_reset_n),
        .pixel_i          (csc_pixel),
        .exp_sel_i        (exp_sel_i),
        .extra_out_mode_i (extra_out_mode_i),
        .analog_o         (analog_o),
        .vga_oe_o         (vga_oe_o)
    );

endmodule

/* verification/tb_video_model.svh */
// Reference model for the video output path: OSD palette, RGB to YPbPr,
// analog sync encoding and the stimulus LFSR
`ifndef TB_VIDEO_MODEL_SVH
`define TB_VIDEO_MODEL_SVH

function automatic logic [23:0] osd_rgb(input video_out_pkg::osd_color_t color);
    logic [23:0] rgb;
    case (color)
        video_out_pkg::OSD_BLACK:  rgb = 24'h000000;
        video_out_pkg::OSD_BLUE:   rgb = 24'h0000ff;
        video_out_pkg::OSD_YELLOW: rgb = 24'hffff00;
        default:                   rgb = 24'hffffff;
    endcase
    return rgb;
endfunction

function automatic video_out_pkg::video_pixel_t mix_pixel(
    input video_out_pkg::video_pixel_t pix,
    input logic                        osd_en,
    input video_out_pkg::osd_color_t   color
);
    video_out_pkg::video_pixel_t mixed;
    mixed = pix;
    if (osd_en) begin
        {mixed.r, mixed.g, mixed.b} = osd_rgb(color);
    end
    return mixed;
endfunction

function automatic logic [7:0] clamp_byte(input int value);
    logic [7:0] res;
    if (value < 0) begin
        res = 8'h00;
    end else if (value > 255) begin
        res = 8'hff;
    end else begin
        res = value[7:0];
    end
    return res;
endfunction

// Coefficients in 1/256 units, floor shift, chroma offset of 128
function automatic video_out_pkg::video_pixel_t convert_ypbpr(
    input video_out_pkg::video_pixel_t pix,
    input logic                        enable
);
    video_out_pkg::video_pixel_t res;
    int r;
    int g;
    int b;
    int y;
    int pb;
    int pr;
    res = pix;
    r   = int'(pix.r);
    g   = int'(pix.g);
    b   = int'(pix.b);
    y   = (77 * r + 150 * g + 29 * b) >>> 8;
    pb  = ((-43 * r - 85 * g + 128 * b) >>> 8) + 128;
    pr  = ((128 * r - 107 * g - 21 * b) >>> 8) + 128;
    if (enable) begin
        res.g = clamp_byte(y);
        res.b = clamp_byte(pb);
        res.r = clamp_byte(pr);
    end
    return res;
endfunction

function automatic video_out_pkg::analog_out_t encode_sync(
    input video_out_pkg::video_pixel_t    pix,
    input video_out_pkg::extra_out_mode_t mode
);
    video_out_pkg::analog_out_t res;
    logic csync;
    csync       = ~(pix.hsync ^ pix.vsync);
    res.r       = pix.r;
    res.g       = pix.g;
    res.b       = pix.b;
    res.hs      = (mode == video_out_pkg::EXTRA_OUT_RGBHV) ? pix.hsync : csync;
    res.vs      = (mode == video_out_pkg::EXTRA_OUT_RGBHV) ? pix.vsync : 1'b1;
    res.blank_n = (mode == video_out_pkg::EXTRA_OUT_YPBPR) ? 1'b1 : pix.de;
    res.sync_n  = (mode == video_out_pkg::EXTRA_OUT_RGSB ||
                   mode == video_out_pkg::EXTRA_OUT_YPBPR) ? csync : 1'b0;
    return res;
endfunction

// x^16 + x^14 + x^13 + x^11 + 1
function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    logic fb;
    fb = state[15] ^ state[13] ^ state[12] ^ state[10];
    return {state[14:0], fb};
endfunction

`endif

/* verification/tb_video_out.sv */
// Testbench for the video output pipeline: table-driven stimulus with
// delayed expected values for the HDMI and analog outputs
`timescale 1ns/100ps

module tb_video_out;

    `include "tb_video_model.svh"

    localparam int HDMI_LATENCY = 2;
    localparam int ANA_LATENCY  = 5;
    localparam int NUM_ROWS     = 18;

    typedef struct packed {
        logic                            osd_en;
        video_out_pkg::osd_color_t       osd_color;
        video_out_pkg::exp_sel_t         exp_sel;
        video_out_pkg::extra_out_mode_t  mode;
        logic                            rand_src;
        video_out_pkg::video_pixel_t     pix;
        logic [7:0]                      count;
    } stim_row_t;

    logic                            pclk_out;
    logic                            po_reset_n;
    video_out_pkg::video_pixel_t     pixel_i;
    logic                            osd_enable_i;
    video_out_pkg::osd_color_t       osd_color_i;
    video_out_pkg::exp_sel_t         exp_sel_i;
    video_out_pkg::extra_out_mode_t  extra_out_mode_i;
    video_out_pkg::video_pixel_t     hdmi_pixel_o;
    video_out_pkg::analog_out_t      analog_o;
    logic                            vga_oe_o;

    stim_row_t                       stim [NUM_ROWS];
    video_out_pkg::video_pixel_t     hdmi_q [$];
    video_out_pkg::analog_out_t      ana_q [$];
    video_out_pkg::analog_out_t      last_ana;
    logic                            ana_known;
    video_out_pkg::exp_sel_t         prev_exp;
    video_out_pkg::extra_out_mode_t  prev_mode;
    int                              run_len;
    logic [15:0]                     lfsr_state;

    video_out_top #(
        .TX_LSB_ZERO (1'b0)
    ) DUT (
        .pclk_out         (pclk_out),
        .po_reset_n       (po_reset_n),
        .pixel_i          (pixel_i),
        .osd_enable_i     (osd_enable_i),
        .osd_color_i      (osd_color_i),
        .exp_sel_i        (exp_sel_i),
        .extra_out_mode_i (extra_out_mode_i),
        .hdmi_pixel_o     (hdmi_pixel_o),
        .analog_o         (analog_o),
        .vga_oe_o         (vga_oe_o)
    );

    always #2 pclk_out = ~pclk_out;

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, actual, expected);
            fail_run("output value mismatch");
        end
    endtask

    task automatic take_bits(input int n, output logic [7:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            val = {val[6:0], lfsr_state[0]};
        end
    endtask

    function automatic video_out_pkg::video_pixel_t fixed_pix(input logic [23:0] rgb,
                                                              input logic hs,
                                                              input logic vs,
                                                              input logic de);
        video_out_pkg::video_pixel_t pix;
        {pix.r, pix.g, pix.b} = rgb;
        pix.hsync = hs;
        pix.vsync = vs;
        pix.de    = de;
        return pix;
    endfunction

    function automatic stim_row_t make_row(input logic osd_en,
                                           input video_out_pkg::osd_color_t color,
                                           input video_out_pkg::exp_sel_t sel,
                                           input video_out_pkg::extra_out_mode_t mode,
                                           input logic rand_src,
                                           input video_out_pkg::video_pixel_t pix,
                                           input logic [7:0] count);
        stim_row_t row;
        row.osd_en    = osd_en;
        row.osd_color = color;
        row.exp_sel   = sel;
        row.mode      = mode;
        row.rand_src  = rand_src;
        row.pix       = pix;
        row.count     = count;
        return row;
    endfunction

    task automatic load_table();
        video_out_pkg::video_pixel_t none;
        none = '0;
        // HDMI path, then the four OSD colours
        stim[0]  = make_row(0, video_out_pkg::OSD_BLACK, video_out_pkg::EXP_SEL_OFF,
                            video_out_pkg::EXTRA_OUT_RGBHV, 1, none, 8'd20);
        stim[1]  = make_row(1, video_out_pkg::OSD_BLACK, video_out_pkg::EXP_SEL_OFF,
                            video_out_pkg::EXTRA_OUT_RGBHV, 1, none, 8'd4);
        stim[2]  = make_row(1, video_out_pkg::OSD_BLUE, video_out_pkg::EXP_SEL_OFF,
                            video_out_pkg::EXTRA_OUT_RGBHV, 1, none, 8'd4);
        stim[3]  = make_row(1, video_out_pkg::OSD_YELLOW, video_out_pkg::EXP_SEL_OFF,
                            video_out_pkg::EXTRA_OUT_RGBHV, 1, none, 8'd4);
        stim[4]  = make_row(1, video_out_pkg::OSD_WHITE, video_out_pkg::EXP_SEL_OFF,
                            video_out_pkg::EXTRA_OUT_RGBHV, 1, none, 8'd4);
        stim[5]  = make_row(1, video_out_pkg::OSD_WHITE, video_out_pkg::EXP_SEL_OFF,
                            video_out_pkg::EXTRA_OUT_RGBHV, 0,
                            fixed_pix(24'h123456, 1, 0, 1), 8'd2);
        // RGB sync formats
        stim[6]  = make_row(0, video_out_pkg::OSD_BLACK, video_out_pkg::EXP_SEL_EXTRA_OUT,
                            video_out_pkg::EXTRA_OUT_RGBHV, 1, none, 8'd12);
        stim[7]  = make_row(0, video_out_pkg::OSD_BLACK, video_out_pkg::EXP_SEL_EXTRA_OUT,
                            video_out_pkg::EXTRA_OUT_RGBCS, 1, none, 8'd12);
        stim[8]  = make_row(0, video_out_pkg::OSD_BLACK, video_out_pkg::EXP_SEL_EXTRA_OUT,
                            video_out_pkg::EXTRA_OUT_RGSB, 1, none, 8'd12);
        // YPbPr with full-scale and primary colours
        stim[9]  = make_row(0, video_out_pkg::OSD_BLACK, video_out_pkg::EXP_SEL_EXTRA_OUT,
                            video_out_pkg::EXTRA_OUT_YPBPR, 0,
                            fixed_pix(24'hffffff, 0, 0, 1), 8'd6);
        stim[10] = make_row(0, video_out_pkg::OSD_BLACK, video_out_pkg::EXP_SEL_EXTRA_OUT,
                            video_out_pkg::EXTRA_OUT_YPBPR, 0,
                            fixed_pix(24'h000000, 1, 0, 0), 8'd6);
        stim[11] = make_row(0, video_out_pkg::OSD_BLACK, video_out_pkg::EXP_SEL_EXTRA_OUT,
                            video_out_pkg::EXTRA_OUT_YPBPR, 0,
                            fixed_pix(24'hff0000, 0, 1, 1), 8'd6);
        stim[12] = make_row(0, video_out_pkg::OSD_BLACK, video_out_pkg::EXP_SEL_EXTRA_OUT,
                            video_out_pkg::EXTRA_OUT_YPBPR, 0,
                            fixed_pix(24'h00ff00, 1, 1, 1), 8'd6);
        stim[13] = make_row(0, video_out_pkg::OSD_BLACK, video_out_pkg::EXP_SEL_EXTRA_OUT,
                            video_out_pkg::EXTRA_OUT_YPBPR, 0,
                            fixed_pix(24'h0000ff, 0, 0, 1), 8'd6);
        stim[14] = make_row(0, video_out_pkg::OSD_BLACK, video_out_pkg::EXP_SEL_EXTRA_OUT,
                            video_out_pkg::EXTRA_OUT_YPBPR, 1, none, 8'd16);
        // Settle in RGBHV, then the port is released and must hold
        stim[15] = make_row(0, video_out_pkg::OSD_BLACK, video_out_pkg::EXP_SEL_EXTRA_OUT,
                            video_out_pkg::EXTRA_OUT_RGBHV, 1, none, 8'd8);
        stim[16] = make_row(0, video_out_pkg::OSD_BLACK, video_out_pkg::EXP_SEL_OFF,
                            video_out_pkg::EXTRA_OUT_RGBHV, 1, none, 8'd16);
        stim[17] = make_row(0, video_out_pkg::OSD_BLACK, video_out_pkg::EXP_SEL_LEGACY_IN,
                            video_out_pkg::EXTRA_OUT_YPBPR, 1, none, 8'd8);
    endtask

    task automatic apply_row(input stim_row_t row);
        video_out_pkg::video_pixel_t pix;
        video_out_pkg::video_pixel_t mixed;
        logic [7:0]                  bits;
        logic                        csc_on;
        pix = row.pix;
        if (row.rand_src) begin
            take_bits(8, bits);
            pix.r = bits;
            take_bits(8, bits);
            pix.g = bits;
            take_bits(8, bits);
            pix.b = bits;
            take_bits(3, bits);
            pix.hsync = bits[2];
            pix.vsync = bits[1];
            pix.de    = bits[0];
        end
        pixel_i          = pix;
        osd_enable_i     = row.osd_en;
        osd_color_i      = row.osd_color;
        exp_sel_i        = row.exp_sel;
        extra_out_mode_i = row.mode;

        csc_on = (row.exp_sel == video_out_pkg::EXP_SEL_EXTRA_OUT) &&
                 (row.mode == video_out_pkg::EXTRA_OUT_YPBPR);
        mixed  = mix_pixel(pix, row.osd_en, row.osd_color);
        hdmi_q.push_back(mixed);
        ana_q.push_back(encode_sync(convert_ypbpr(mixed, csc_on), row.mode));

        if (row.exp_sel == prev_exp && row.mode == prev_mode) begin
            run_len++;
        end else begin
            run_len = 1;
        end
        prev_exp  = row.exp_sel;
        prev_mode = row.mode;
    endtask

    // Analog values are only predictable once the controls were steady
    // over the whole five-cycle path
    task automatic check_outputs();
        video_out_pkg::video_pixel_t hdmi_exp;
        video_out_pkg::analog_out_t  ana_exp;
        hdmi_exp = hdmi_q.pop_front();
        ana_exp  = ana_q.pop_front();
        check_value("hdmi_pixel_o", 32'(hdmi_pixel_o), 32'(hdmi_exp));
        check_value("vga_oe_o", 32'(vga_oe_o),
                    32'(prev_exp == video_out_pkg::EXP_SEL_EXTRA_OUT));
        if (prev_exp != video_out_pkg::EXP_SEL_EXTRA_OUT) begin
            if (ana_known) begin
                check_value("analog_o", 32'(analog_o), 32'(last_ana));
            end
        end else if (run_len >= ANA_LATENCY) begin
            check_value("analog_o", 32'(analog_o), 32'(ana_exp));
            last_ana  = ana_exp;
            ana_known = 1'b1;
        end else begin
            ana_known = 1'b0;
        end
    endtask

    initial begin
        pclk_out         = 1'b0;
        po_reset_n       = 1'b0;
        pixel_i          = '0;
        osd_enable_i     = 1'b0;
        osd_color_i      = video_out_pkg::OSD_BLACK;
        exp_sel_i        = video_out_pkg::EXP_SEL_OFF;
        extra_out_mode_i = video_out_pkg::EXTRA_OUT_RGBHV;
        lfsr_state       = 16'd48547;
        prev_exp         = video_out_pkg::EXP_SEL_OFF;
        prev_mode        = video_out_pkg::EXTRA_OUT_RGBHV;
        run_len          = 0;
        last_ana         = '0;
        ana_known        = 1'b1;
        load_table();

        for (int i = 0; i < 16; i++) begin
            @(negedge pclk_out);
            check_value("hdmi_pixel_o.de", 32'(hdmi_pixel_o.de), 32'd0);
            check_value("hdmi_pixel_o.hsync", 32'(hdmi_pixel_o.hsync), 32'd0);
            check_value("hdmi_pixel_o.vsync", 32'(hdmi_pixel_o.vsync), 32'd0);
            check_value("vga_oe_o", 32'(vga_oe_o), 32'd0);
        end
        po_reset_n = 1'b1;

        // Registers come out of reset at zero
        for (int i = 0; i < HDMI_LATENCY; i++) begin
            hdmi_q.push_back('0);
        end
        for (int i = 0; i < ANA_LATENCY; i++) begin
            ana_q.push_back('0);
        end

        for (int i = 0; i < NUM_ROWS; i++) begin
            for (int n = 0; n < int'(stim[i].count); n++) begin
                @(negedge pclk_out);
                check_outputs();
                apply_row(stim[i]);
            end
        end
        @(negedge pclk_out);
        check_outputs();

        $display("NO ERRORS");
        $finish;
    end

endmodule

/* project.f */
+incdir+verification
logic/video_out_pkg.sv
logic/osd_mixer.sv
logic/ypbpr_csc.sv
logic/analog_sync_encoder.sv
logic/video_out_top.sv
verification/tb_video_out.sv

/* run_sim.sh */
#!/bin/sh
# Builds the video output testbench with Verilator and runs it.
# The run passes only if the testbench prints its pass line.
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -j 0 \
    --top-module tb_video_out \
    -f project.f \
    -o tb_video_out &&
./obj_dir/tb_video_out | tee /dev/stderr | grep -q "^NO ERRORS$" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
